/* isaPkg.sv */
package isaPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int immWidth = 16;
    localparam int targetWidth = 26;

    // Primary opcodes
    localparam logic [opcodeWidth-1:0] opR = 6'b000000;
    localparam logic [opcodeWidth-1:0] opAddi = 6'b001000;
    localparam logic [opcodeWidth-1:0] opAddiu = 6'b001001;
    localparam logic [opcodeWidth-1:0] opSlti = 6'b001010;
    localparam logic [opcodeWidth-1:0] opBeq = 6'b000100;
    localparam logic [opcodeWidth-1:0] opBne = 6'b000101;
    localparam logic [opcodeWidth-1:0] opBle = 6'b000110;
    localparam logic [opcodeWidth-1:0] opBgt = 6'b000111;
    localparam logic [opcodeWidth-1:0] opJ = 6'b000010;
    localparam logic [opcodeWidth-1:0] opJal = 6'b000011;

    // Funct codes under opR
    localparam logic [functWidth-1:0] functAdd = 6'b100000;
    localparam logic [functWidth-1:0] functSub = 6'b100010;
    localparam logic [functWidth-1:0] functAnd = 6'b100100;
    localparam logic [functWidth-1:0] functSlt = 6'b101010;
    localparam logic [functWidth-1:0] functJr = 6'b001000;
    localparam logic [functWidth-1:0] functRte = 6'b010011;

    // Same word seen as R-type or I-type, J target is iType[25:0]
    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] shamt;
            logic [functWidth-1:0] funct;
        } rType;
        struct packed {
            logic [opcodeWidth-1:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [immWidth-1:0] imm;
        } iType;
    } instrWord;

endpackage

/* corePkg.sv */
package corePkg;

    // ALU operations
    localparam int aluOpWidth = 3;
    localparam logic [aluOpWidth-1:0] aluPassA = 3'd0;
    localparam logic [aluOpWidth-1:0] aluAdd = 3'd1;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd2;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
    localparam logic [aluOpWidth-1:0] aluCompare = 3'd4;

    // Operand selects, A and B share a width
    localparam int srcWidth = 2;
    localparam logic [srcWidth-1:0] srcPc = 2'd0;
    localparam logic [srcWidth-1:0] srcRegA = 2'd1;
    localparam logic [srcWidth-1:0] srcFour = 2'd0;
    localparam logic [srcWidth-1:0] srcRegB = 2'd1;
    localparam logic [srcWidth-1:0] srcImm = 2'd2;
    localparam logic [srcWidth-1:0] srcBranchOffset = 2'd3;

    // Next PC sources
    localparam int pcSourceWidth = 3;
    localparam logic [pcSourceWidth-1:0] pcFromAlu = 3'd0;
    localparam logic [pcSourceWidth-1:0] pcFromAluOut = 3'd1;
    localparam logic [pcSourceWidth-1:0] pcFromJump = 3'd2;
    localparam logic [pcSourceWidth-1:0] pcFromEpc = 3'd3;
    localparam logic [pcSourceWidth-1:0] pcFromHandler = 3'd4;

    localparam int regDstWidth = 2;
    localparam logic [regDstWidth-1:0] dstRt = 2'd0;
    localparam logic [regDstWidth-1:0] dstRd = 2'd1;
    localparam logic [regDstWidth-1:0] dstRa = 2'd2;

    localparam logic wbAluOut = 1'b0;
    localparam logic wbLessThan = 1'b1;

    typedef enum logic [3:0] {
        stReset, stFetch, stWait, stDecode, stAluOp, stBranch, stJump, stJal, stException
    } cpuState;

    localparam logic [31:0] handlerOverflow = 32'h0000_0100;
    localparam logic [31:0] handlerIllegal = 32'h0000_0180;
    localparam logic [31:0] resetVector = 32'h0000_0000;

endpackage

/* controlBus.sv */
`timescale 1ns/1ps

interface controlBus;
    // Control word from the FSM
    logic [corePkg::aluOpWidth-1:0] aluOp;
    logic [corePkg::srcWidth-1:0] srcA;
    logic [corePkg::srcWidth-1:0] srcB;
    logic aluOutWrite;
    logic regLatch;
    logic regWrite;
    logic [corePkg::regDstWidth-1:0] regDst;
    logic wbSource;
    logic pcWrite;
    logic [corePkg::pcSourceWidth-1:0] pcSource;
    logic epcWrite;
    logic fetchStart;

    // Status back from the datapath
    isaPkg::instrWord instr;
    logic instrReady;
    logic equal;
    logic greater;
    logic lessThan;
    logic overflow;

    modport controller (
        output aluOp, srcA, srcB, aluOutWrite, regLatch, regWrite, regDst, wbSource,
        output pcWrite, pcSource, epcWrite, fetchStart,
        input instr, instrReady, equal, greater, lessThan, overflow
    );

    modport datapath (
        input aluOp, srcA, srcB, aluOutWrite, regLatch, regWrite, regDst, wbSource,
        input pcWrite, pcSource, epcWrite, fetchStart,
        output instr, instrReady, equal, greater, lessThan, overflow
    );
endinterface

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input logic clock,
    input logic reset,
    controlBus.controller bus
);

    corePkg::cpuState state;
    corePkg::cpuState execState;
    logic step;

    logic [isaPkg::opcodeWidth-1:0] opcode;
    logic [isaPkg::functWidth-1:0] funct;
    logic [corePkg::aluOpWidth-1:0] execOp;
    logic [corePkg::pcSourceWidth-1:0] jumpSource;
    logic useImm;
    logic checkOverflow;
    logic lessResult;
    logic branchTaken;

    assign opcode = bus.instr.rType.opcode;
    assign funct = bus.instr.rType.funct;

    // Instruction decode, unknown encodings fall through to passA and exception
    always_comb begin
        execOp = corePkg::aluPassA;
        execState = corePkg::stException;
        useImm = 1'b0;
        checkOverflow = 1'b0;
        lessResult = 1'b0;
        case (opcode)
            isaPkg::opR: begin
                case (funct)
                    isaPkg::functAdd: begin
                        execOp = corePkg::aluAdd;
                        checkOverflow = 1'b1;
                        execState = corePkg::stAluOp;
                    end
                    isaPkg::functSub: begin
                        execOp = corePkg::aluSub;
                        checkOverflow = 1'b1;
                        execState = corePkg::stAluOp;
                    end
                    isaPkg::functAnd: begin
                        execOp = corePkg::aluAnd;
                        execState = corePkg::stAluOp;
                    end
                    isaPkg::functSlt: begin
                        execOp = corePkg::aluCompare;
                        lessResult = 1'b1;
                        execState = corePkg::stAluOp;
                    end
                    isaPkg::functJr, isaPkg::functRte: execState = corePkg::stJump;
                    default: execState = corePkg::stException;
                endcase
            end
            isaPkg::opAddi: begin
                execOp = corePkg::aluAdd;
                useImm = 1'b1;
                checkOverflow = 1'b1;
                execState = corePkg::stAluOp;
            end
            // Wraps silently, no overflow check
            isaPkg::opAddiu: begin
                execOp = corePkg::aluAdd;
                useImm = 1'b1;
                execState = corePkg::stAluOp;
            end
            isaPkg::opSlti: begin
                execOp = corePkg::aluCompare;
                useImm = 1'b1;
                lessResult = 1'b1;
                execState = corePkg::stAluOp;
            end
            isaPkg::opBeq, isaPkg::opBne, isaPkg::opBle, isaPkg::opBgt: begin
                execOp = corePkg::aluCompare;
                execState = corePkg::stBranch;
            end
            isaPkg::opJ: execState = corePkg::stJump;
            isaPkg::opJal: execState = corePkg::stJal;
            default: execState = corePkg::stException;
        endcase
    end

    // Signed branch conditions
    always_comb begin
        case (opcode)
            isaPkg::opBeq: branchTaken = bus.equal;
            isaPkg::opBne: branchTaken = !bus.equal;
            isaPkg::opBle: branchTaken = bus.equal || bus.lessThan;
            isaPkg::opBgt: branchTaken = bus.greater;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == isaPkg::opJ) begin
            jumpSource = corePkg::pcFromJump;
        end else if (funct == isaPkg::functRte) begin
            jumpSource = corePkg::pcFromEpc;
        end else begin
            jumpSource = corePkg::pcFromAlu;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= corePkg::stReset;
            step <= 1'b0;
        end else begin
            step <= 1'b0;
            case (state)
                corePkg::stReset: state <= corePkg::stFetch;
                corePkg::stFetch: state <= corePkg::stWait;
                corePkg::stWait: begin
                    if (bus.instrReady) begin
                        state <= corePkg::stDecode;
                    end
                end
                corePkg::stDecode: state <= execState;
                corePkg::stAluOp: begin
                    if (!step && checkOverflow && bus.overflow) begin
                        // Straight to the EPC write step
                        state <= corePkg::stException;
                        step <= 1'b1;
                    end else if (!step) begin
                        step <= 1'b1;
                    end else begin
                        state <= corePkg::stFetch;
                    end
                end
                corePkg::stBranch: begin
                    if (!step && branchTaken) begin
                        step <= 1'b1;
                    end else begin
                        state <= corePkg::stFetch;
                    end
                end
                corePkg::stJal, corePkg::stException: begin
                    if (!step) begin
                        step <= 1'b1;
                    end else begin
                        state <= corePkg::stFetch;
                    end
                end
                default: state <= corePkg::stFetch;
            endcase
        end
    end

    // Moore outputs, the execute selects stay put for every step after decode
    always_comb begin
        bus.aluOp = execOp;
        bus.srcA = corePkg::srcRegA;
        bus.srcB = useImm ? corePkg::srcImm : corePkg::srcRegB;
        bus.aluOutWrite = 1'b0;
        bus.regLatch = 1'b0;
        bus.regWrite = 1'b0;
        bus.regDst = (opcode == isaPkg::opR) ? corePkg::dstRd : corePkg::dstRt;
        bus.wbSource = lessResult ? corePkg::wbLessThan : corePkg::wbAluOut;
        bus.pcWrite = 1'b0;
        bus.pcSource = jumpSource;
        bus.epcWrite = 1'b0;
        bus.fetchStart = 1'b0;
        case (state)
            corePkg::stFetch: bus.fetchStart = 1'b1;
            corePkg::stDecode: begin
                // Branch target into aluOut, or the return address for jal
                bus.srcA = corePkg::srcPc;
                bus.srcB = corePkg::srcBranchOffset;
                bus.aluOp = (opcode == isaPkg::opJal) ? corePkg::aluPassA : corePkg::aluAdd;
                bus.aluOutWrite = 1'b1;
                bus.regLatch = 1'b1;
            end
            corePkg::stAluOp: begin
                bus.aluOutWrite = !step;
                bus.regWrite = step;
            end
            corePkg::stBranch: begin
                bus.pcWrite = step;
                bus.pcSource = corePkg::pcFromAluOut;
            end
            corePkg::stJump: bus.pcWrite = 1'b1;
            corePkg::stJal: begin
                bus.regWrite = !step;
                bus.regDst = corePkg::dstRa;
                bus.wbSource = corePkg::wbAluOut;
                bus.pcWrite = step;
                bus.pcSource = corePkg::pcFromJump;
            end
            corePkg::stException: begin
                bus.epcWrite = step;
                bus.pcWrite = step;
                bus.pcSource = corePkg::pcFromHandler;
            end
            default: bus.fetchStart = 1'b0;
        endcase
    end

    stateDefined: assert property (@(posedge clock) disable iff (reset)
        state inside {[corePkg::stReset:corePkg::stException]});

    noWriteClash: assert property (@(posedge clock) disable iff (reset)
        !(bus.regWrite && bus.pcWrite));

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input logic clock,
    input logic reset,
    controlBus.datapath bus,
    input logic [isaPkg::dataWidth-1:0] aluResult,
    input logic [isaPkg::dataWidth-1:0] aluOut,
    output logic fetchRequest,
    output logic [isaPkg::dataWidth-1:0] fetchAddr,
    input logic fetchValid,
    input logic [isaPkg::dataWidth-1:0] fetchData
);

    logic [isaPkg::dataWidth-1:0] pc;
    logic [isaPkg::dataWidth-1:0] epc;
    logic [isaPkg::dataWidth-1:0] nextPc;
    isaPkg::instrWord instrReg;
    logic credit;

    assign fetchRequest = bus.fetchStart;
    assign fetchAddr = pc;
    assign bus.instr = instrReg;

    always_comb begin
        case (bus.pcSource)
            corePkg::pcFromAlu: nextPc = aluResult;
            corePkg::pcFromAluOut: nextPc = aluOut;
            corePkg::pcFromJump: begin
                nextPc = {pc[31:28], instrReg.iType[isaPkg::targetWidth-1:0], 2'b00};
            end
            corePkg::pcFromEpc: nextPc = epc;
            // Operands are still held, so the overflow flag names the cause
            corePkg::pcFromHandler: begin
                nextPc = bus.overflow ? corePkg::handlerOverflow : corePkg::handlerIllegal;
            end
            default: nextPc = pc;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= corePkg::resetVector;
            credit <= 1'b1;
            bus.instrReady <= 1'b0;
        end else begin
            bus.instrReady <= fetchValid;
            if (fetchValid) begin
                pc <= pc + 32'd4;
            end else if (bus.pcWrite) begin
                pc <= nextPc;
            end
            // One credit, spent on request and returned by the response
            if (fetchRequest) begin
                credit <= 1'b0;
            end else if (fetchValid) begin
                credit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetchValid) begin
            instrReg <= fetchData;
        end
        // PC already points past the faulting instruction
        if (bus.epcWrite) begin
            epc <= pc - 32'd4;
        end
    end

    requestNeedsCredit: assert property (@(posedge clock) disable iff (reset)
        fetchRequest |-> credit);

    responseNeedsRequest: assert property (@(posedge clock) disable iff (reset)
        fetchValid |-> !credit);

endmodule

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input logic clock,
    input logic reset,
    controlBus.datapath bus,
    input logic [isaPkg::dataWidth-1:0] writeData,
    output logic [isaPkg::dataWidth-1:0] regA,
    output logic [isaPkg::dataWidth-1:0] regB,
    output logic regWriteValid,
    output logic [isaPkg::regAddrWidth-1:0] regWriteAddr
);

    logic [isaPkg::dataWidth-1:0] regs [32];
    logic [isaPkg::regAddrWidth-1:0] rs;
    logic [isaPkg::regAddrWidth-1:0] rt;

    assign rs = bus.instr.rType.rs;
    assign rt = bus.instr.rType.rt;
    assign regWriteValid = bus.regWrite;

    always_comb begin
        case (bus.regDst)
            corePkg::dstRd: regWriteAddr = bus.instr.rType.rd;
            corePkg::dstRa: regWriteAddr = 5'd31;
            default: regWriteAddr = bus.instr.iType.rt;
        endcase
    end

    // $0 is never stored, a write to it only shows on the trace
    always_ff @(posedge clock) begin
        if (bus.regWrite && regWriteAddr != '0) begin
            regs[regWriteAddr] <= writeData;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regA <= '0;
            regB <= '0;
        end else if (bus.regLatch) begin
            regA <= (rs == '0) ? '0 : regs[rs];
            regB <= (rt == '0) ? '0 : regs[rt];
        end
    end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input logic clock,
    input logic reset,
    controlBus.datapath bus,
    input logic [isaPkg::dataWidth-1:0] pc,
    input logic [isaPkg::dataWidth-1:0] regA,
    input logic [isaPkg::dataWidth-1:0] regB,
    output logic [isaPkg::dataWidth-1:0] aluResult,
    output logic [isaPkg::dataWidth-1:0] aluOut,
    output logic [isaPkg::dataWidth-1:0] writeData
);

    logic [isaPkg::dataWidth-1:0] operandA;
    logic [isaPkg::dataWidth-1:0] operandB;
    logic [isaPkg::dataWidth-1:0] signImm;
    logic [isaPkg::dataWidth-1:0] sum;
    logic [isaPkg::dataWidth-1:0] difference;

    assign signImm = {{16{bus.instr.iType.imm[15]}}, bus.instr.iType.imm};
    assign operandA = (bus.srcA == corePkg::srcPc) ? pc : regA;

    always_comb begin
        case (bus.srcB)
            corePkg::srcFour: operandB = 32'd4;
            corePkg::srcRegB: operandB = regB;
            corePkg::srcImm: operandB = signImm;
            default: operandB = {signImm[29:0], 2'b00};
        endcase
    end

    assign sum = operandA + operandB;
    assign difference = operandA - operandB;

    // Flags compare signed operands
    assign bus.equal = (operandA == operandB);
    assign bus.greater = ($signed(operandA) > $signed(operandB));
    assign bus.lessThan = ($signed(operandA) < $signed(operandB));

    always_comb begin
        bus.overflow = 1'b0;
        case (bus.aluOp)
            corePkg::aluAdd: begin
                aluResult = sum;
                bus.overflow = (operandA[31] == operandB[31]) && (sum[31] != operandA[31]);
            end
            corePkg::aluSub: begin
                aluResult = difference;
                bus.overflow = (operandA[31] != operandB[31])
                    && (difference[31] != operandA[31]);
            end
            corePkg::aluAnd: aluResult = operandA & operandB;
            corePkg::aluCompare: aluResult = difference;
            default: aluResult = operandA;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            aluOut <= '0;
        end else if (bus.aluOutWrite) begin
            aluOut <= aluResult;
        end
    end

    assign writeData = (bus.wbSource == corePkg::wbLessThan) ? {31'b0, bus.lessThan} : aluOut;

endmodule

/* cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input logic clock,
    input logic reset,
    output logic fetchRequest,
    output logic [31:0] fetchAddr,
    input logic fetchValid,
    input logic [31:0] fetchData,
    output logic regWriteValid,
    output logic [4:0] regWriteAddr,
    output logic [31:0] regWriteData
);

    logic [31:0] aluResult;
    logic [31:0] aluOut;
    logic [31:0] regA;
    logic [31:0] regB;

    controlBus bus ();

    controlUnit control (
        .clock(clock),
        .reset(reset),
        .bus(bus.controller)
    );

    fetchUnit fetch (
        .clock(clock),
        .reset(reset),
        .bus(bus.datapath),
        .aluResult(aluResult),
        .aluOut(aluOut),
        .fetchRequest(fetchRequest),
        .fetchAddr(fetchAddr),
        .fetchValid(fetchValid),
        .fetchData(fetchData)
    );

    registerFile registers (
        .clock(clock),
        .reset(reset),
        .bus(bus.datapath),
        .writeData(regWriteData),
        .regA(regA),
        .regB(regB),
        .regWriteValid(regWriteValid),
        .regWriteAddr(regWriteAddr)
    );

    // fetchAddr doubles as the PC operand
    aluUnit alu (
        .clock(clock),
        .reset(reset),
        .bus(bus.datapath),
        .pc(fetchAddr),
        .regA(regA),
        .regB(regB),
        .aluResult(aluResult),
        .aluOut(aluOut),
        .writeData(regWriteData)
    );

endmodule

/* tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;

    // Roughly 80 instructions, each under 20 cycles at the longest fetch delay, plus margin
    localparam int timeoutCycles = 4000;

    logic clock;
    logic reset;
    logic fetchRequest;
    logic [31:0] fetchAddr;
    logic fetchValid;
    logic [31:0] fetchData;
    logic regWriteValid;
    logic [4:0] regWriteAddr;
    logic [31:0] regWriteData;

    logic [31:0] mem [128];
    logic [31:0] fetchLog[$];
    logic [31:0] writeAddrLog[$];
    logic [31:0] writeDataLog[$];
    logic [31:0] expectFetch[$];
    logic [31:0] expectAddr[$];
    logic [31:0] expectData[$];
    logic [31:0] requestAddr;
    logic pending;
    int waitCycles;
    int delayBase;
    int delaySpan;
    int cycleCount;
    integer seed;

    cpuTop UUT (.*);

    always #4 clock = ~clock;

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] encodeR(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
            logic [4:0] rd);
        return {isaPkg::opR, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(logic [5:0] op, logic [25:0] target);
        return {op, target};
    endfunction

    // Offset counts words from the instruction after the branch
    function automatic logic [31:0] branchNext(logic [31:0] pc, logic [15:0] offset,
            logic taken);
        return taken ? pc + 32'd4 + {{14{offset[15]}}, offset, 2'b00} : pc + 32'd4;
    endfunction

    // Target stays inside the 256 MB region of the next PC
    function automatic logic [31:0] jumpNext(logic [31:0] pc, logic [25:0] target);
        logic [31:0] pcPlus4;
        pcPlus4 = pc + 32'd4;
        return {pcPlus4[31:28], target, 2'b00};
    endfunction

    task automatic putWord(logic [31:0] addr, logic [31:0] word);
        mem[addr[8:2]] = word;
    endtask

    task automatic expectWrite(logic [4:0] regNum, logic [31:0] data);
        expectAddr.push_back({27'd0, regNum});
        expectData.push_back(data);
    endtask

    task automatic expectFetchRange(logic [31:0] first, logic [31:0] last);
        logic [31:0] addr;
        addr = first;
        while (addr <= last) begin
            expectFetch.push_back(addr);
            addr = addr + 32'd4;
        end
    endtask

    task automatic beginTest(int base, int span);
        @(posedge clock);
        #1;
        reset = 1'b1;
        delayBase = base;
        delaySpan = span;
        for (int i = 0; i < 128; i++) begin
            // Unknown opcode tagged with its own byte address
            mem[i] = {6'h3f, 10'd0, 16'(i * 4)};
        end
        fetchLog.delete();
        writeAddrLog.delete();
        writeDataLog.delete();
        expectFetch.delete();
        expectAddr.delete();
        expectData.delete();
    endtask

    task automatic runAndCheck();
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        while (fetchLog.size() < expectFetch.size()) begin
            @(negedge clock);
        end
        foreach (expectFetch[i]) begin
            checkValue("fetchAddr", fetchLog[i], expectFetch[i]);
        end
        checkValue("write count", writeAddrLog.size(), expectAddr.size());
        foreach (expectAddr[i]) begin
            checkValue("regWriteAddr", writeAddrLog[i], expectAddr[i]);
            checkValue("regWriteData", writeDataLog[i], expectData[i]);
        end
    endtask

    task automatic testArithmetic(int base, int span);
        logic [31:0] a;
        logic [31:0] b;
        beginTest(base, span);
        a = 32'h0000_7fff;
        b = 32'hffff_fffd;
        putWord(32'h00, encodeI(isaPkg::opAddi, 5'd0, 5'd1, 16'h7fff));
        putWord(32'h04, encodeI(isaPkg::opAddiu, 5'd0, 5'd2, 16'hfffd));
        putWord(32'h08, encodeR(isaPkg::functAdd, 5'd1, 5'd2, 5'd3));
        putWord(32'h0c, encodeR(isaPkg::functSub, 5'd2, 5'd1, 5'd4));
        putWord(32'h10, encodeR(isaPkg::functAnd, 5'd1, 5'd2, 5'd5));
        putWord(32'h14, encodeR(isaPkg::functSlt, 5'd2, 5'd1, 5'd6));
        putWord(32'h18, encodeR(isaPkg::functSlt, 5'd1, 5'd2, 5'd7));
        putWord(32'h1c, encodeI(isaPkg::opSlti, 5'd2, 5'd8, 16'hfffe));
        putWord(32'h20, encodeI(isaPkg::opSlti, 5'd1, 5'd9, 16'h0005));
        // Write to $0 shows on the trace, then $0 must still read zero
        putWord(32'h24, encodeI(isaPkg::opAddi, 5'd1, 5'd0, 16'h0001));
        putWord(32'h28, encodeR(isaPkg::functAdd, 5'd0, 5'd1, 5'd10));
        expectWrite(5'd1, a);
        expectWrite(5'd2, b);
        expectWrite(5'd3, a + b);
        expectWrite(5'd4, b - a);
        expectWrite(5'd5, a & b);
        expectWrite(5'd6, {31'd0, $signed(b) < $signed(a)});
        expectWrite(5'd7, {31'd0, $signed(a) < $signed(b)});
        expectWrite(5'd8, {31'd0, $signed(b) < $signed(32'hffff_fffe)});
        expectWrite(5'd9, {31'd0, $signed(a) < $signed(32'd5)});
        expectWrite(5'd0, a + 32'd1);
        expectWrite(5'd10, a);
        expectFetchRange(32'h00, 32'h2c);
        runAndCheck();
    endtask

    task automatic testBranches();
        logic [31:0] v1;
        logic [31:0] v2;
        beginTest(1, 4);
        v1 = 32'd5;
        v2 = 32'hffff_fffd;
        putWord(32'h00, encodeI(isaPkg::opAddi, 5'd0, 5'd1, 16'h0005));
        putWord(32'h04, encodeI(isaPkg::opAddiu, 5'd0, 5'd2, 16'hfffd));
        putWord(32'h08, encodeI(isaPkg::opAddi, 5'd0, 5'd3, 16'h0005));
        // Skipped slots keep the illegal fill
        putWord(32'h0c, encodeI(isaPkg::opBeq, 5'd1, 5'd3, 16'h0001));
        putWord(32'h14, encodeI(isaPkg::opBeq, 5'd1, 5'd2, 16'h0005));
        putWord(32'h18, encodeI(isaPkg::opBne, 5'd1, 5'd2, 16'h0001));
        putWord(32'h20, encodeI(isaPkg::opBne, 5'd1, 5'd3, 16'h0005));
        putWord(32'h24, encodeI(isaPkg::opBle, 5'd2, 5'd1, 16'h0001));
        putWord(32'h2c, encodeI(isaPkg::opBle, 5'd1, 5'd2, 16'h0005));
        putWord(32'h30, encodeI(isaPkg::opBgt, 5'd1, 5'd2, 16'h0001));
        putWord(32'h38, encodeI(isaPkg::opBgt, 5'd2, 5'd1, 16'h0005));
        putWord(32'h3c, encodeI(isaPkg::opAddi, 5'd0, 5'd4, 16'h0001));
        expectWrite(5'd1, v1);
        expectWrite(5'd2, v2);
        expectWrite(5'd3, v1);
        expectWrite(5'd4, 32'd1);
        expectFetchRange(32'h00, 32'h0c);
        expectFetch.push_back(branchNext(32'h0c, 16'h0001, v1 == v1));
        expectFetch.push_back(branchNext(32'h14, 16'h0005, v1 == v2));
        expectFetch.push_back(branchNext(32'h18, 16'h0001, v1 != v2));
        expectFetch.push_back(branchNext(32'h20, 16'h0005, v1 != v1));
        expectFetch.push_back(branchNext(32'h24, 16'h0001, $signed(v2) <= $signed(v1)));
        expectFetch.push_back(branchNext(32'h2c, 16'h0005, $signed(v1) <= $signed(v2)));
        expectFetch.push_back(branchNext(32'h30, 16'h0001, $signed(v1) > $signed(v2)));
        expectFetch.push_back(branchNext(32'h38, 16'h0005, $signed(v2) > $signed(v1)));
        expectFetch.push_back(32'h40);
        runAndCheck();
    endtask

    task automatic testJumps();
        beginTest(1, 4);
        putWord(32'h00, encodeJ(isaPkg::opJ, 26'h000003));
        putWord(32'h0c, encodeJ(isaPkg::opJal, 26'h000008));
        putWord(32'h20, encodeR(isaPkg::functJr, 5'd31, 5'd0, 5'd0));
        putWord(32'h10, encodeI(isaPkg::opAddi, 5'd0, 5'd5, 16'h0007));
        expectWrite(5'd31, 32'h0c + 32'd4);
        expectWrite(5'd5, 32'd7);
        expectFetch.push_back(32'h00);
        expectFetch.push_back(jumpNext(32'h00, 26'h000003));
        expectFetch.push_back(jumpNext(32'h0c, 26'h000008));
        expectFetch.push_back(32'h0c + 32'd4);
        expectFetch.push_back(32'h14);
        runAndCheck();
    endtask

    task automatic testExceptions();
        logic [31:0] value;
        beginTest(1, 4);
        value = 32'h0000_4000;
        putWord(32'h00, encodeI(isaPkg::opAddi, 5'd0, 5'd1, 16'h4000));
        expectWrite(5'd1, value);
        // Doubling up to 2^30, one more doubling overflows
        for (int k = 1; k <= 16; k++) begin
            putWord(32'(k * 4), encodeR(isaPkg::functAdd, 5'd1, 5'd1, 5'd1));
            value = value + value;
            expectWrite(5'd1, value);
        end
        putWord(32'h44, encodeR(isaPkg::functAdd, 5'd1, 5'd1, 5'd2));
        putWord(32'h48, encodeI(6'h3e, 5'd0, 5'd0, 16'h0000));
        // Overflow handler shrinks $1 so the retried add fits
        putWord(corePkg::handlerOverflow, encodeI(isaPkg::opAddi, 5'd0, 5'd1, 16'h0001));
        putWord(corePkg::handlerOverflow + 32'd4, encodeR(isaPkg::functRte, 5'd0, 5'd0, 5'd0));
        putWord(corePkg::handlerIllegal, encodeI(isaPkg::opAddi, 5'd0, 5'd6, 16'h0009));
        putWord(corePkg::handlerIllegal + 32'd4, encodeR(isaPkg::functRte, 5'd0, 5'd0, 5'd0));
        expectWrite(5'd1, 32'd1);
        expectWrite(5'd2, 32'd2);
        expectWrite(5'd6, 32'd9);
        expectFetchRange(32'h00, 32'h44);
        expectFetch.push_back(corePkg::handlerOverflow);
        expectFetch.push_back(corePkg::handlerOverflow + 32'd4);
        expectFetch.push_back(32'h44);
        expectFetch.push_back(32'h48);
        expectFetch.push_back(corePkg::handlerIllegal);
        expectFetch.push_back(corePkg::handlerIllegal + 32'd4);
        expectFetch.push_back(32'h48);
        runAndCheck();
    endtask

    task automatic testBackPressure();
        logic [31:0] shortData[$];
        testArithmetic(1, 1);
        shortData = writeDataLog;
        // 6 to 13 cycles per fetch
        testArithmetic(6, 8);
        checkValue("write count", writeDataLog.size(), shortData.size());
        foreach (shortData[i]) begin
            checkValue("regWriteData", writeDataLog[i], shortData[i]);
        end
    endtask

    // Requests are taken at the falling edge, one outstanding at most
    always @(negedge clock) begin
        if (reset) begin
            pending = 1'b0;
            waitCycles = 0;
        end else if (fetchRequest && pending) begin
            abortRun("A second fetch request arrived before the previous response");
        end else if (fetchRequest) begin
            pending = 1'b1;
            requestAddr = fetchAddr;
            waitCycles = delayBase + ($unsigned($random(seed)) % delaySpan);
            fetchLog.push_back(fetchAddr);
        end
    end

    always @(posedge clock) begin
        #1;
        fetchValid = 1'b0;
        if (pending) begin
            waitCycles = waitCycles - 1;
            if (waitCycles <= 0) begin
                fetchValid = 1'b1;
                fetchData = mem[requestAddr[8:2]];
                pending = 1'b0;
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && regWriteValid) begin
            writeAddrLog.push_back({27'd0, regWriteAddr});
            writeDataLog.push_back(regWriteData);
        end
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            abortRun("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchData = 32'd0;
        requestAddr = 32'd0;
        pending = 1'b0;
        waitCycles = 0;
        delayBase = 1;
        delaySpan = 1;
        cycleCount = 0;
        seed = 32'h6413_2d21;
        testArithmetic(1, 4);
        testBranches();
        testJumps();
        testExceptions();
        testBackPressure();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* project.f */
isaPkg.sv
corePkg.sv
controlBus.sv
controlUnit.sv
fetchUnit.sv
registerFile.sv
aluUnit.sv
cpuTop.sv
tbCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbCpu -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/VtbCpu
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0
